// ==== hdl/ntt_pkg.sv ====
package ntt_pkg;

    // transform geometry
    localparam int N_POINTS      = 16;
    localparam int N_STAGES      = 4;
    localparam int N_BUTTERFLIES = N_POINTS / 2;

    // word width when the top level does not override it
    localparam int DEFAULT_D_WIDTH = 16;

    // 4-bit index reversal, used for the twiddle lookup
    function automatic logic [3:0] bit_rev4(input logic [3:0] idx);
        logic [3:0] rev;
        for (int i = 0; i < 4; i++) begin
            rev[i] = idx[3 - i];
        end
        return rev;
    endfunction

endpackage

// ==== hdl/ntt_stage_if.sv ====
`timescale 1ns/100ps

interface ntt_stage_if #(
    parameter int D_WIDTH = ntt_pkg::DEFAULT_D_WIDTH
);

    import ntt_pkg::*;

    // one item as it sits between two stages
    logic               valid;
    logic [D_WIDTH-1:0] coef    [N_POINTS];
    logic [D_WIDTH-1:0] twiddle [N_POINTS];
    logic [D_WIDTH-1:0] modulus;

    modport src (
        output valid,
        output coef,
        output twiddle,
        output modulus
    );

    modport dst (
        input valid,
        input coef,
        input twiddle,
        input modulus
    );

endinterface

// ==== hdl/ct_butterfly.sv ====
`timescale 1ns/100ps

module ct_butterfly #(
    parameter int D_WIDTH = 16
) (
    input  logic [D_WIDTH-1:0] x,
    input  logic [D_WIDTH-1:0] y,
    input  logic [D_WIDTH-1:0] w,
    input  logic [D_WIDTH-1:0] q,
    output logic [D_WIDTH-1:0] a,
    output logic [D_WIDTH-1:0] b
);

    logic [2*D_WIDTH-1:0] prod;
    logic [2*D_WIDTH-1:0] prod_red;
    logic [D_WIDTH-1:0]   t;

    logic [D_WIDTH:0] q_ext;
    logic [D_WIDTH:0] sum;
    logic [D_WIDTH:0] sum_sub;
    logic [D_WIDTH:0] diff;
    logic [D_WIDTH:0] diff_sub;

    // double-width product, then reduce mod q
    assign prod     = (2 * D_WIDTH)'(w) * (2 * D_WIDTH)'(y);
    assign prod_red = prod % (2 * D_WIDTH)'(q);
    assign t        = prod_red[D_WIDTH-1:0];

    assign q_ext = {1'b0, q};

    // x + t lies in 0..2q-2
    assign sum     = {1'b0, x} + {1'b0, t};
    assign sum_sub = sum - q_ext;

    // x - t + q lies in 1..2q-1, never negative
    assign diff     = {1'b0, x} + q_ext - {1'b0, t};
    assign diff_sub = diff - q_ext;

    // one conditional subtract brings each back below q
    always_comb begin
        if (sum >= q_ext) begin
            a = sum_sub[D_WIDTH-1:0];
        end else begin
            a = sum[D_WIDTH-1:0];
        end

        if (diff >= q_ext) begin
            b = diff_sub[D_WIDTH-1:0];
        end else begin
            b = diff[D_WIDTH-1:0];
        end
    end

endmodule

// ==== hdl/ntt_stage.sv ====
`timescale 1ns/100ps

module ntt_stage #(
    parameter int D_WIDTH = 16,
    parameter int STAGE   = 0
) (
    input logic      clk,
    input logic      rst,
    ntt_stage_if.dst prev,
    ntt_stage_if.src next
);

    import ntt_pkg::*;

    // block size halves at every stage
    localparam int BLOCK = N_POINTS >> STAGE;
    localparam int HALF  = BLOCK / 2;

    logic [D_WIDTH-1:0] res [N_POINTS];

    for (genvar j = 0; j < N_BUTTERFLIES; j++) begin : g_bfly
        // block k, position p within it
        localparam int K  = j / HALF;
        localparam int P  = j % HALF;
        localparam int LO = K * BLOCK + P;
        localparam int HI = LO + HALF;

        // every pair in block k shares one twiddle
        localparam logic [3:0] TW_IDX = bit_rev4(4'((1 << STAGE) + K));

        ct_butterfly #(
            .D_WIDTH (D_WIDTH)
        ) i_bfly (
            .x (prev.coef[LO]),
            .y (prev.coef[HI]),
            .w (prev.twiddle[TW_IDX]),
            .q (prev.modulus),
            .a (res[LO]),
            .b (res[HI])
        );
    end

    // results go back into the positions they came from
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            next.valid <= 1'b0;
            for (int i = 0; i < N_POINTS; i++) begin
                next.coef[i] <= '0;
            end
        end else begin
            next.valid <= prev.valid;
            for (int i = 0; i < N_POINTS; i++) begin
                next.coef[i] <= res[i];
            end
        end
    end

    // item parameters move on with the coefficients
    always_ff @(posedge clk) begin
        for (int i = 0; i < N_POINTS; i++) begin
            next.twiddle[i] <= prev.twiddle[i];
        end
        next.modulus <= prev.modulus;
    end

endmodule

// ==== hdl/r16_ntt_core.sv ====
`timescale 1ns/100ps

module r16_ntt_core #(
    parameter int D_WIDTH = ntt_pkg::DEFAULT_D_WIDTH
) (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic [ntt_pkg::N_POINTS-1:0][D_WIDTH-1:0] x,
    input  logic [ntt_pkg::N_POINTS-1:0][D_WIDTH-1:0] twiddle,
    input  logic [D_WIDTH-1:0]                         modulus,
    input  logic                                       in_valid,
    output logic [ntt_pkg::N_POINTS-1:0][D_WIDTH-1:0] y,
    output logic                                       out_valid
);

    import ntt_pkg::*;

    ntt_stage_if #(.D_WIDTH(D_WIDTH)) slice_0 ();
    ntt_stage_if #(.D_WIDTH(D_WIDTH)) slice_1 ();
    ntt_stage_if #(.D_WIDTH(D_WIDTH)) slice_2 ();
    ntt_stage_if #(.D_WIDTH(D_WIDTH)) slice_3 ();
    ntt_stage_if #(.D_WIDTH(D_WIDTH)) slice_4 ();

    // input ports into the first slice, natural order
    assign slice_0.valid   = in_valid;
    assign slice_0.modulus = modulus;

    for (genvar i = 0; i < N_POINTS; i++) begin : g_unpack
        assign slice_0.coef[i]    = x[i];
        assign slice_0.twiddle[i] = twiddle[i];
    end

    // 16-point blocks first, 2-point blocks last
    ntt_stage #(
        .D_WIDTH (D_WIDTH),
        .STAGE   (0)
    ) i_stage_0 (
        .clk  (clk),
        .rst  (rst),
        .prev (slice_0.dst),
        .next (slice_1.src)
    );

    ntt_stage #(
        .D_WIDTH (D_WIDTH),
        .STAGE   (1)
    ) i_stage_1 (
        .clk  (clk),
        .rst  (rst),
        .prev (slice_1.dst),
        .next (slice_2.src)
    );

    ntt_stage #(
        .D_WIDTH (D_WIDTH),
        .STAGE   (2)
    ) i_stage_2 (
        .clk  (clk),
        .rst  (rst),
        .prev (slice_2.dst),
        .next (slice_3.src)
    );

    ntt_stage #(
        .D_WIDTH (D_WIDTH),
        .STAGE   (3)
    ) i_stage_3 (
        .clk  (clk),
        .rst  (rst),
        .prev (slice_3.dst),
        .next (slice_4.src)
    );

    // output register, bit-reversed order as left in place
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
            y         <= '0;
        end else begin
            out_valid <= slice_4.valid;
            for (int i = 0; i < N_POINTS; i++) begin
                y[i] <= slice_4.coef[i];
            end
        end
    end

endmodule

// ==== sim/ntt_ref_model.svh ====
`ifndef NTT_REF_MODEL_SVH
`define NTT_REF_MODEL_SVH

// expects the ntt_pkg names to be imported where this is included
typedef logic [N_POINTS-1:0][DEFAULT_D_WIDTH-1:0] coef_vec_t;

// in-place radix-2 transform over 16 points, arithmetic done at 64 bits
function automatic coef_vec_t ntt_ref_16(
    input coef_vec_t                  coef,
    input coef_vec_t                  tw,
    input logic [DEFAULT_D_WIDTH-1:0] q
);
    longint unsigned v [N_POINTS];
    longint unsigned qq;
    longint unsigned t;
    longint unsigned x0;
    int              m;
    int              h;
    int              lo;
    int              hi;
    logic [3:0]      widx;
    coef_vec_t       res;

    qq = 64'(q);
    for (int i = 0; i < N_POINTS; i++) begin
        v[i] = 64'(coef[i]);
    end

    for (int s = 0; s < N_STAGES; s++) begin
        m = N_POINTS >> s;
        h = m / 2;
        for (int k = 0; k < N_POINTS / m; k++) begin
            // one twiddle per block
            widx = bit_rev4(4'((1 << s) + k));
            for (int p = 0; p < h; p++) begin
                lo    = k * m + p;
                hi    = lo + h;
                t     = (64'(tw[widx]) * v[hi]) % qq;
                x0    = v[lo];
                v[lo] = (x0 + t) % qq;
                v[hi] = (x0 + qq - t) % qq;
            end
        end
    end

    for (int i = 0; i < N_POINTS; i++) begin
        res[i] = DEFAULT_D_WIDTH'(v[i]);
    end
    return res;
endfunction

`endif

// ==== sim/tb_r16_ntt.sv ====
`timescale 1ns/100ps

module tb_r16_ntt;

    import ntt_pkg::*;

    `include "ntt_ref_model.svh"

    localparam int W           = DEFAULT_D_WIDTH;
    localparam int LATENCY     = N_STAGES + 1;
    localparam int DRAIN_LIMIT = 40;

    logic          clk;
    logic          rst;
    coef_vec_t     x;
    coef_vec_t     twiddle;
    logic [W-1:0]  modulus;
    logic          in_valid;
    coef_vec_t     y;
    logic          out_valid;

    integer        seed;
    int            cycle_cnt = 0;
    int            error_cnt = 0;
    int            check_cnt = 0;
    bit            timed_out = 1'b0;
    coef_vec_t     exp_q [$];
    int            enter_q [$];
    int            primes [5] = '{17, 257, 3329, 7681, 12289};

    r16_ntt_core #(
        .D_WIDTH (W)
    ) i_dut (
        .clk       (clk),
        .rst       (rst),
        .x         (x),
        .twiddle   (twiddle),
        .modulus   (modulus),
        .in_valid  (in_valid),
        .y         (y),
        .out_valid (out_valid)
    );

    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin : compare
        coef_vec_t exp_y;
        int        enter;
        if (!rst && out_valid) begin
            if (exp_q.size() == 0) begin
                error_cnt++;
                $display("out_valid went high at cycle %0d with no item in flight",
                         cycle_cnt);
            end else begin
                exp_y = exp_q.pop_front();
                enter = enter_q.pop_front();
                for (int i = 0; i < N_POINTS; i++) begin
                    check_value($sformatf("y[%0d]", i), 64'(y[i]), 64'(exp_y[i]));
                end
                check_value("latency", 64'(cycle_cnt - enter), 64'(LATENCY));
            end
        end
    end

    function automatic logic [W-1:0] rand_below(input logic [W-1:0] q);
        return W'($unsigned($random(seed)) % q);
    endfunction

    function automatic void random_operands(input logic [W-1:0] q,
                                            output coef_vec_t xv, output coef_vec_t tv);
        for (int i = 0; i < N_POINTS; i++) begin
            xv[i] = rand_below(q);
            tv[i] = rand_below(q);
        end
    endfunction

    // item is taken on the next rising edge, counted from this one
    task automatic apply_item(input coef_vec_t xv, input coef_vec_t tv,
                              input logic [W-1:0] q);
        @(posedge clk);
        #2;
        x        = xv;
        twiddle  = tv;
        modulus  = q;
        in_valid = 1'b1;
        exp_q.push_back(ntt_ref_16(xv, tv, q));
        enter_q.push_back(cycle_cnt);
    endtask

    task automatic apply_idle();
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            timed_out = 1'b1;
            $display("timeout: %0d items never came out of the pipeline", exp_q.size());
        end
        // a few more edges so a stray pulse gets seen
        repeat (3) @(posedge clk);
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("test %-8s finished, %0d errors", name, error_cnt - err_before);
    endtask

    task automatic test_reset();
        int err_before;
        err_before = error_cnt;
        for (int c = 0; c < 6; c++) begin
            @(negedge clk);
            check_value("out_valid", 64'(out_valid), 64'(0));
            for (int i = 0; i < N_POINTS; i++) begin
                check_value($sformatf("y[%0d]", i), 64'(y[i]), 64'(0));
            end
        end
        report_test("reset", err_before);
    endtask

    task automatic test_single();
        int        err_before;
        coef_vec_t xv;
        coef_vec_t tv;
        err_before = error_cnt;
        random_operands(W'(7681), xv, tv);
        apply_item(xv, tv, W'(7681));
        apply_idle();
        wait_drain();
        report_test("single", err_before);
    endtask

    task automatic test_stream();
        int           err_before;
        coef_vec_t    xv;
        coef_vec_t    tv;
        logic [W-1:0] q;
        err_before = error_cnt;
        for (int n = 0; n < 40; n++) begin
            q = W'(primes[$unsigned($random(seed)) % 5]);
            random_operands(q, xv, tv);
            apply_item(xv, tv, q);
        end
        apply_idle();
        wait_drain();
        report_test("stream", err_before);
    endtask

    task automatic test_gapped();
        int           err_before;
        coef_vec_t    xv;
        coef_vec_t    tv;
        logic [W-1:0] q;
        err_before = error_cnt;
        for (int n = 0; n < 60; n++) begin
            if ($random(seed) & 1) begin
                q = W'(primes[$unsigned($random(seed)) % 5]);
                random_operands(q, xv, tv);
                apply_item(xv, tv, q);
            end else begin
                apply_idle();
            end
        end
        apply_idle();
        wait_drain();
        report_test("gapped", err_before);
    endtask

    // unit twiddles with coefficients at both ends of the range
    task automatic test_edges();
        int           err_before;
        coef_vec_t    xv;
        coef_vec_t    tv;
        logic [W-1:0] q;
        err_before = error_cnt;
        for (int pi = 0; pi < 5; pi++) begin
            q = W'(primes[pi]);
            for (int pat = 0; pat < 3; pat++) begin
                for (int i = 0; i < N_POINTS; i++) begin
                    tv[i] = W'(1);
                    if (pat == 0) begin
                        xv[i] = '0;
                    end else if (pat == 1) begin
                        xv[i] = q - 1'b1;
                    end else begin
                        xv[i] = (i % 2 == 0) ? q - 1'b1 : '0;
                    end
                end
                apply_item(xv, tv, q);
            end
        end
        apply_idle();
        wait_drain();
        report_test("edges", err_before);
    endtask

    initial begin
        coef_vec_t xv;
        coef_vec_t tv;
        seed     = 34;
        random_operands(W'(7681), xv, tv);

        // a live item at the inputs while reset holds the pipeline empty
        rst      = 1'b1;
        x        = xv;
        twiddle  = tv;
        modulus  = W'(7681);
        in_valid = 1'b1;

        repeat (10) @(posedge clk);
        #2;
        rst      = 1'b0;
        x        = '0;
        in_valid = 1'b0;

        test_reset();
        if (!timed_out) begin
            test_single();
        end
        if (!timed_out) begin
            test_stream();
        end
        if (!timed_out) begin
            test_gapped();
        end
        if (!timed_out) begin
            test_edges();
        end

        $display("checks %0d, errors %0d", check_cnt, error_cnt);
        if (!timed_out && error_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== r16_ntt.f ====
+incdir+sim
hdl/ntt_pkg.sv
hdl/ntt_stage_if.sv
hdl/ct_butterfly.sv
hdl/ntt_stage.sv
hdl/r16_ntt_core.sv
sim/tb_r16_ntt.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the r16_ntt testbench with Verilator.
# Exits non-zero unless the log holds the pass line.

set -u

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
EXE=sim_r16_ntt
LOG=sim.log

verilator --binary --timing -Wno-fatal \
    -f r16_ntt.f \
    --top-module tb_r16_ntt \
    -Mdir "$BUILD_DIR" \
    -o "$EXE"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator compile failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$EXE" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST OK$" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG"
    exit 1
fi
